/* flist.f */
+incdir+include
verilog/vdp_pkg.sv
verilog/vdp_register.sv
verilog/vdp_vram_access.sv
verilog/vdp_ssg.sv
verilog/vdp_interrupt.sv
verilog/vdp_color_out.sv
verilog/vdp.sv
tests/tb_clock.sv
tests/tb_vdp.sv

/* tests/tb_vdp.sv */
// VDP core testbench
// Drives the CPU port and raster inputs, models VRAM, and checks VRAM
// traffic, read-ahead data, backdrop RGB and both interrupt sources

`include "vdp_cfg.svh"

module tb_vdp import vdp_pkg::*; ();

  // Port accesses per test, used to size the run limit
  localparam int ACCESSES  = 12 + 12 + 44 + 4 + 7;
  localparam int TIMEOUT   = ACCESSES * 8 + 400;
  localparam int VRAM_SIZE = 1 << `VDP_VRAM_AW;

  logic RESET, CLK21M;
  logic req, ack, wrt, int_n, vram_we_n, scanlin;
  port_mode_e mode;
  vdp_data_t dbo, dbi, vram_dbo, vram_dbi;
  vram_addr_t vram_adr;
  logic [9:0] cx, cy;
  video_t red, green, blue;

  vdp_data_t  mem [VRAM_SIZE];
  vram_addr_t wr_adr_q[$];
  vdp_data_t  wr_dat_q[$];
  pal_entry_t pal_model [`VDP_PAL_ENTRIES];
  color_code_t bd_model;
  logic [31:0] rng;
  logic [23:0] exp_rgb;
  logic rgb_chk;
  int errors, checks, cycles;

  tb_clock #(.PERIOD(40), .RST_CYCLES(5)) u_clock (.clk(RESET), .rst(CLK21M));

  vdp vdp_i (
    .RESET(RESET), .CLK21M(CLK21M), .req(req), .ack(ack), .wrt(wrt), .mode(mode),
    .dbo(dbo), .dbi(dbi), .int_n(int_n), .vram_we_n(vram_we_n), .vram_adr(vram_adr),
    .vram_dbo(vram_dbo), .vram_dbi(vram_dbi), .cx(cx), .cy(cy), .scanlin(scanlin),
    .red(red), .green(green), .blue(blue)
  );

  // --------------------
  // VRAM model
  // --------------------
  assign vram_dbi = mem[vram_adr];

  always @(negedge RESET) begin
    if (!vram_we_n) begin
      mem[vram_adr] = vram_dbo;
      wr_adr_q.push_back(vram_adr);
      wr_dat_q.push_back(vram_dbo);
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Expected backdrop RGB from palette entry and raster position
  function automatic logic [23:0] ref_rgb(input pal_entry_t e, input logic [9:0] x,
                                          input logic [9:0] y, input logic scan);
    logic [7:0] r, g, b;
    r = {e.r, e.r, e.r[2:1]};
    g = {e.g, e.g, e.g[2:1]};
    b = {e.b, e.b, e.b[2:1]};
    if (scan && y[0]) begin
      r = r >> 1;
      g = g >> 1;
      b = b >> 1;
    end
    if (x >= `VDP_H_VISIBLE || y >= `VDP_V_VISIBLE) return 24'd0;
    return {r, g, b};
  endfunction

  // --------------------
  // Compare tasks
  // --------------------
  task automatic compare_data(input string name, input vdp_data_t got, input vdp_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  task automatic compare_addr(input string name, input vram_addr_t got, input vram_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  task automatic compare_video(input string name, input video_t got, input video_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  task automatic compare_level(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
    end
  endtask

  // RGB follows its inputs two clocks later, so only held inputs are checked
  always @(negedge RESET) begin
    if (rgb_chk) begin
      exp_rgb = ref_rgb(pal_model[bd_model], cx, cy, scanlin);
      compare_video("red", red, exp_rgb[23:16]);
      compare_video("green", green, exp_rgb[15:8]);
      compare_video("blue", blue, exp_rgb[7:0]);
    end
  end

  always @(posedge RESET) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  // --------------------
  // CPU port tasks
  // --------------------
  task automatic step(input int n = 1);
    repeat (n) begin
      @(posedge RESET);
      #2;
    end
  endtask

  task automatic port_access(input logic w, input port_mode_e m, input vdp_data_t d,
                             output vdp_data_t q);
    int n;
    n = 0;
    wrt = w;
    mode = m;
    dbo = d;
    req = 1'b1;
    do begin
      step();
      n++;
    end while (!ack && n < 20);
    if (!ack) begin
      errors++;
      $display("No ack from the CPU port at time %0t", $time);
    end
    q = dbi;
    req = 1'b0;
    step();
  endtask

  task automatic reg_write(input int num, input vdp_data_t val);
    vdp_data_t q;
    port_access(1'b1, PORT_CTRL, val, q);
    port_access(1'b1, PORT_CTRL, 8'h80 | vdp_data_t'(num), q);
  endtask

  task automatic set_addr(input vram_addr_t a, input logic for_write);
    vdp_data_t q;
    reg_write(14, {5'd0, a[16:14]});
    port_access(1'b1, PORT_CTRL, a[7:0], q);
    port_access(1'b1, PORT_CTRL, {1'b0, for_write, a[13:8]}, q);
  endtask

  task automatic wait_int_low();
    int n;
    n = 0;
    while (int_n && n < 16) begin
      step();
      n++;
    end
    if (int_n) begin
      errors++;
      $display("Interrupt request never went low at time %0t", $time);
    end
  endtask

  task automatic rgb_case(input logic [9:0] x, input logic [9:0] y, input logic scan,
                          input color_code_t bd);
    rgb_chk = 1'b0;
    cx = x;
    cy = y;
    scanlin = scan;
    reg_write(7, {4'd0, bd});
    bd_model = bd;
    step(3);
    rgb_chk = 1'b1;
    step(8);
    rgb_chk = 1'b0;
  endtask

  task automatic end_test(input string name, input int err_before);
    if (errors == err_before) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - err_before);
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    vram_addr_t a;
    vdp_data_t  q;
    vdp_data_t  exp_q[$];
    pal_entry_t e;
    int e0, n;
    req = 1'b0;
    wrt = 1'b0;
    mode = PORT_DATA;
    dbo = '0;
    cx = '0;
    cy = '0;
    scanlin = 1'b0;
    rgb_chk = 1'b0;
    bd_model = '0;
    errors = 0;
    checks = 0;
    cycles = 0;
    rng = 32'd16553;
    for (int i = 0; i < VRAM_SIZE; i++) begin
      rng = xorshift(rng);
      mem[i] = rng[7:0];
    end
    @(negedge CLK21M);
    step();

    e0 = errors;
    compare_level("ack", ack, 1'b0);
    compare_level("int_n", int_n, 1'b1);
    compare_level("vram_we_n", vram_we_n, 1'b1);
    end_test("reset", e0);

    // Eight writes from a random start address
    e0 = errors;
    rng = xorshift(rng);
    a = rng[`VDP_VRAM_AW-1:0];
    set_addr(a, 1'b1);
    for (int i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      exp_q.push_back(rng[7:0]);
      port_access(1'b1, PORT_DATA, rng[7:0], q);
    end
    n = 0;
    while (wr_adr_q.size() < 8 && n < 16) begin
      step();
      n++;
    end
    if (wr_adr_q.size() != 8) begin
      errors++;
      $display("VRAM saw %0d writes where 8 were sent", wr_adr_q.size());
    end else begin
      for (int i = 0; i < 8; i++) begin
        compare_addr("vram_adr", wr_adr_q[i], a + vram_addr_t'(i));
        compare_data("vram_dbo", wr_dat_q[i], exp_q[i]);
      end
    end
    end_test("vram write", e0);

    // Reads straddle the end of the written block
    e0 = errors;
    a = a + vram_addr_t'(4);
    set_addr(a, 1'b0);
    for (int i = 0; i < 8; i++) begin
      port_access(1'b0, PORT_DATA, 8'h00, q);
      compare_data("dbi", q, mem[a + vram_addr_t'(i)]);
    end
    end_test("vram read", e0);

    e0 = errors;
    reg_write(16, 8'h00);
    for (int i = 0; i < `VDP_PAL_ENTRIES; i++) begin
      rng = xorshift(rng);
      e = rng[8:0];
      pal_model[i] = e;
      port_access(1'b1, PORT_PALETTE, {1'b0, e.r, 1'b0, e.b}, q);
      port_access(1'b1, PORT_PALETTE, {5'd0, e.g}, q);
    end
    rgb_case(10'd100, 10'd50, 1'b0, 4'd5);
    rgb_case(10'd100, 10'd51, 1'b1, 4'd5);
    rgb_case(10'd300, 10'd52, 1'b1, 4'd12);
    rgb_case(10'd700, 10'd52, 1'b0, 4'd15);
    rgb_case(10'd100, 10'd500, 1'b0, 4'd3);
    end_test("backdrop rgb", e0);

    e0 = errors;
    reg_write(1, 8'h20);
    cx = 10'd0;
    cy = `VDP_VBLANK_CY;
    wait_int_low();
    cx = 10'd1;
    port_access(1'b0, PORT_CTRL, 8'h00, q);
    compare_data("dbi S0", q, 8'h80);
    compare_level("int_n", int_n, 1'b1);
    port_access(1'b0, PORT_CTRL, 8'h00, q);
    compare_data("dbi S0", q, 8'h00);
    end_test("vertical interrupt", e0);

    // Raster line 200 is display line 80, a hit that must not match
    e0 = errors;
    cx = `VDP_HINT_CX;
    cy = 10'd200;
    reg_write(19, 8'h21);
    reg_write(0, 8'h10);
    reg_write(15, 8'h01);
    compare_level("int_n", int_n, 1'b1);
    cx = 10'd1;
    step();
    // Display line 0x21 sits on raster line TOP + 66
    cy = `VDP_TOP_CY + 10'd66;
    cx = `VDP_HINT_CX;
    wait_int_low();
    cx = 10'd1;
    port_access(1'b0, PORT_CTRL, 8'h00, q);
    compare_data("dbi S1", q, 8'h01);
    compare_level("int_n", int_n, 1'b1);
    end_test("line interrupt", e0);

    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* tests/tb_clock.sv */
// Testbench clock and reset source
// Free-running clock and an active-high reset held for a few cycles

module tb_clock #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #2 rst = 1'b0;
  end

endmodule

/* verilog/vdp.sv */
// VDP core top level
// Connects the CPU port registers, the VRAM access slot, the raster
// event generator, the interrupt logic and the backdrop colour output

module vdp import vdp_pkg::*; (
  input  logic       RESET,
  input  logic       CLK21M,
  input  logic       req,
  output logic       ack,
  input  logic       wrt,
  input  port_mode_e mode,
  input  vdp_data_t  dbo,
  output vdp_data_t  dbi,
  output logic       int_n,
  output logic       vram_we_n,
  output vram_addr_t vram_adr,
  output vdp_data_t  vram_dbo,
  input  vdp_data_t  vram_dbi,
  input  logic [9:0] cx,
  input  logic [9:0] cy,
  input  logic       scanlin,
  output video_t     red,
  output video_t     green,
  output video_t     blue
);

  // CPU port to VRAM slot
  logic        busy;
  vdp_data_t   rd_buf;
  logic        addr_set;
  vram_addr_t  set_addr;
  logic        wr_req;
  vdp_data_t   wr_data;
  logic        rd_req;

  // Interrupt side
  logic        flag_v;
  logic        flag_h;
  logic        clr_v;
  logic        clr_h;
  logic        ie0;
  logic        ie1;
  vdp_data_t   hint_line;

  // Palette and raster
  logic        pal_we;
  color_code_t pal_idx;
  pal_entry_t  pal_rgb;
  color_code_t backdrop;
  dot_state_e  dot_state;
  logic        vblank_start;
  logic        line_hit;
  vdp_data_t   line;
  logic        visible;

  vdp_register u_register (
    .RESET(RESET), .CLK21M(CLK21M), .req(req), .ack(ack), .wrt(wrt), .mode(mode),
    .dbo(dbo), .dbi(dbi), .busy(busy), .rd_buf(rd_buf), .addr_set(addr_set),
    .set_addr(set_addr), .wr_req(wr_req), .wr_data(wr_data), .rd_req(rd_req),
    .flag_v(flag_v), .flag_h(flag_h), .clr_v(clr_v), .clr_h(clr_h), .ie0(ie0),
    .ie1(ie1), .hint_line(hint_line), .pal_we(pal_we), .pal_idx(pal_idx),
    .pal_rgb(pal_rgb), .backdrop(backdrop)
  );

  vdp_vram_access u_vram_access (
    .RESET(RESET), .CLK21M(CLK21M), .dot_state(dot_state), .addr_set(addr_set),
    .set_addr(set_addr), .wr_req(wr_req), .wr_data(wr_data), .rd_req(rd_req),
    .busy(busy), .rd_buf(rd_buf), .vram_we_n(vram_we_n), .vram_adr(vram_adr),
    .vram_dbo(vram_dbo), .vram_dbi(vram_dbi)
  );

  vdp_ssg u_ssg (
    .RESET(RESET), .CLK21M(CLK21M), .cx(cx), .cy(cy), .dot_state(dot_state),
    .vblank_start(vblank_start), .line_hit(line_hit), .line(line), .visible(visible)
  );

  vdp_interrupt u_interrupt (
    .RESET(RESET), .CLK21M(CLK21M), .vblank_start(vblank_start), .line_hit(line_hit),
    .line(line), .hint_line(hint_line), .ie0(ie0), .ie1(ie1), .clr_v(clr_v),
    .clr_h(clr_h), .flag_v(flag_v), .flag_h(flag_h), .int_n(int_n)
  );

  vdp_color_out u_color_out (
    .RESET(RESET), .CLK21M(CLK21M), .pal_we(pal_we), .pal_idx(pal_idx),
    .pal_rgb(pal_rgb), .backdrop(backdrop), .visible(visible), .cy(cy),
    .scanlin(scanlin), .red(red), .green(green), .blue(blue)
  );

endmodule

/* verilog/vdp_color_out.sv */
// VDP backdrop colour output
// 16-entry palette, backdrop lookup and expansion to 8-bit RGB
// with blanking and optional scanline dimming

`include "vdp_cfg.svh"

module vdp_color_out import vdp_pkg::*; (
  input  logic        RESET,
  input  logic        CLK21M,
  input  logic        pal_we,
  input  color_code_t pal_idx,
  input  pal_entry_t  pal_rgb,
  input  color_code_t backdrop,
  input  logic        visible,
  input  logic [9:0]  cy,
  input  logic        scanlin,
  output video_t      red,
  output video_t      green,
  output video_t      blue
);

  pal_entry_t pal [`VDP_PAL_ENTRIES];
  pal_entry_t ent_q;
  logic       dim_q;

  // Replicate 3 bits up to 8, halve on dimmed lines
  function automatic video_t expand(input logic [2:0] c, input logic dim);
    video_t full;
    full = {c, c, c[2:1]};
    return dim ? (full >> 1) : full;
  endfunction

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      for (int i = 0; i < `VDP_PAL_ENTRIES; i++) pal[i] <= '0;
      ent_q <= '0;
      dim_q <= 1'b0;
      red <= '0;
      green <= '0;
      blue <= '0;
    end else begin
      if (pal_we) pal[pal_idx] <= pal_rgb;
      // Stage 1 lookup, visible is already one clock behind
      ent_q <= pal[backdrop];
      dim_q <= scanlin & cy[0];
      red <= visible ? expand(ent_q.r, dim_q) : '0;
      green <= visible ? expand(ent_q.g, dim_q) : '0;
      blue <= visible ? expand(ent_q.b, dim_q) : '0;
    end
  end

endmodule

/* verilog/vdp_interrupt.sv */
// VDP interrupt logic
// Pending vertical and line-match flags, cleared by status reads,
// combined with their enables into one active-low request

module vdp_interrupt import vdp_pkg::*; (
  input  logic      RESET,
  input  logic      CLK21M,
  input  logic      vblank_start,
  input  logic      line_hit,
  input  vdp_data_t line,
  input  vdp_data_t hint_line,
  input  logic      ie0,
  input  logic      ie1,
  input  logic      clr_v,
  input  logic      clr_h,
  output logic      flag_v,
  output logic      flag_h,
  output logic      int_n
);

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      flag_v <= 1'b0;
      flag_h <= 1'b0;
    end else begin
      // A new event wins over a clearing read
      if (vblank_start) flag_v <= 1'b1;
      else if (clr_v) flag_v <= 1'b0;
      if (line_hit && line == hint_line) flag_h <= 1'b1;
      else if (clr_h) flag_h <= 1'b0;
    end
  end

  assign int_n = ~((flag_v & ie0) | (flag_h & ie1));

endmodule

/* verilog/vdp_ssg.sv */
// VDP raster event generator
// Runs the dot state sequence and turns the raster position into
// vertical blank and line-match pulses and a visible flag

`include "vdp_cfg.svh"

module vdp_ssg import vdp_pkg::*; (
  input  logic       RESET,
  input  logic       CLK21M,
  input  logic [9:0] cx,
  input  logic [9:0] cy,
  output dot_state_e dot_state,
  output logic       vblank_start,
  output logic       line_hit,
  output vdp_data_t  line,
  output logic       visible
);

  logic       vb_cond, vb_q;
  logic       hit_cond, hit_q;
  logic [9:0] cy_rel;

  assign vb_cond  = (cx == 10'd0) && (cy == `VDP_VBLANK_CY);
  assign hit_cond = (cx == `VDP_HINT_CX) && !cy[0] && (cy >= `VDP_TOP_CY);
  // Two raster lines per display line
  assign cy_rel   = cy - `VDP_TOP_CY;

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      dot_state <= DOT_S0;
      vb_q <= 1'b0;
      hit_q <= 1'b0;
      vblank_start <= 1'b0;
      line_hit <= 1'b0;
      line <= '0;
      visible <= 1'b0;
    end else begin
      case (dot_state)
        DOT_S0:  dot_state <= DOT_S1;
        DOT_S1:  dot_state <= DOT_S2;
        DOT_S2:  dot_state <= DOT_S3;
        default: dot_state <= DOT_S0;
      endcase
      vb_q <= vb_cond;
      hit_q <= hit_cond;
      vblank_start <= vb_cond & ~vb_q;
      line_hit <= hit_cond & ~hit_q;
      line <= cy_rel[8:1];
      visible <= (cx < `VDP_H_VISIBLE) && (cy < `VDP_V_VISIBLE);
    end
  end

endmodule

/* verilog/vdp_vram_access.sv */
// VDP VRAM access slot
// Holds the auto-incrementing VRAM pointer and one pending CPU access,
// performs it in the slot dot state and keeps the read-ahead byte

`include "vdp_cfg.svh"

module vdp_vram_access import vdp_pkg::*; (
  input  logic       RESET,
  input  logic       CLK21M,
  input  dot_state_e dot_state,
  input  logic       addr_set,
  input  vram_addr_t set_addr,
  input  logic       wr_req,
  input  vdp_data_t  wr_data,
  input  logic       rd_req,
  output logic       busy,
  output vdp_data_t  rd_buf,
  output logic       vram_we_n,
  output vram_addr_t vram_adr,
  output vdp_data_t  vram_dbo,
  input  vdp_data_t  vram_dbi
);

  vram_addr_t ptr;
  vdp_data_t  wr_q;
  logic       pend_wr;
  logic       pend_rd;
  logic       slot;

  assign slot      = (dot_state == dot_state_e'(`VDP_SLOT_PHASE));
  assign busy      = pend_wr | pend_rd;
  assign vram_adr  = ptr;
  assign vram_dbo  = wr_q;
  assign vram_we_n = ~(pend_wr & slot);

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      ptr <= '0;
      pend_wr <= 1'b0;
      pend_rd <= 1'b0;
    end else begin
      // Access done, step the pointer
      if (slot && busy) begin
        pend_wr <= 1'b0;
        pend_rd <= 1'b0;
        ptr <= ptr + 1'b1;
      end
      if (wr_req) pend_wr <= 1'b1;
      if (rd_req) pend_rd <= 1'b1;
      if (addr_set) ptr <= set_addr;
    end
  end

  always_ff @(posedge RESET) begin
    if (wr_req) wr_q <= wr_data;
    if (slot && pend_rd) rd_buf <= vram_dbi;
  end

  // The CPU port only issues a new access once the previous one is done
  a_no_req_busy: assert property (@(posedge RESET) disable iff (CLK21M)
    (wr_req || rd_req) |-> !busy);

  // Write strobe sits in the slot and lasts one clock
  a_we_slot: assert property (@(posedge RESET) disable iff (CLK21M)
    !vram_we_n |-> slot ##1 vram_we_n);

endmodule

/* verilog/vdp_register.sv */
// VDP CPU port
// Decodes the data, control, palette and indirect port modes, holds the
// control registers and first-byte latches, returns status bytes and
// drives the req/ack handshake and the strobes to the VRAM slot

module vdp_register import vdp_pkg::*; (
  input  logic        RESET,
  input  logic        CLK21M,
  input  logic        req,
  output logic        ack,
  input  logic        wrt,
  input  port_mode_e  mode,
  input  vdp_data_t   dbo,
  output vdp_data_t   dbi,
  input  logic        busy,
  input  vdp_data_t   rd_buf,
  output logic        addr_set,
  output vram_addr_t  set_addr,
  output logic        wr_req,
  output vdp_data_t   wr_data,
  output logic        rd_req,
  input  logic        flag_v,
  input  logic        flag_h,
  output logic        clr_v,
  output logic        clr_h,
  output logic        ie0,
  output logic        ie1,
  output vdp_data_t   hint_line,
  output logic        pal_we,
  output color_code_t pal_idx,
  output pal_entry_t  pal_rgb,
  output color_code_t backdrop
);

  vdp_data_t r0, r1, r7, r14, r15, r16, r19;
  vdp_data_t ctrl_lat;
  vdp_data_t pal_lat;
  logic      ctrl_first;
  logic      pal_first;
  logic      accept;
  vdp_data_t rd_mux;

  // Data port accesses hold off while the slot is still busy
  assign accept = req && !ack && !(mode == PORT_DATA && busy);

  assign ie0       = r1[5];
  assign ie1       = r0[4];
  assign hint_line = r19;
  assign backdrop  = r7[3:0];

  always_comb begin
    rd_mux = '0;
    case (mode)
      PORT_DATA: rd_mux = rd_buf;
      PORT_CTRL: begin
        if (r15 == 8'd0) rd_mux = {flag_v, 7'd0};
        else if (r15 == 8'd1) rd_mux = {7'd0, flag_h};
      end
      default: rd_mux = '0;
    endcase
  end

  // --------------------
  // Handshake, strobes and registers
  // --------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      ack <= 1'b0;
      addr_set <= 1'b0;
      wr_req <= 1'b0;
      rd_req <= 1'b0;
      clr_v <= 1'b0;
      clr_h <= 1'b0;
      pal_we <= 1'b0;
      ctrl_first <= 1'b0;
      pal_first <= 1'b0;
      r0 <= '0;
      r1 <= '0;
      r7 <= '0;
      r14 <= '0;
      r15 <= '0;
      r16 <= '0;
      r19 <= '0;
    end else begin
      ack <= accept;
      addr_set <= 1'b0;
      wr_req <= 1'b0;
      rd_req <= 1'b0;
      clr_v <= 1'b0;
      clr_h <= 1'b0;
      pal_we <= 1'b0;
      if (accept) begin
        case (mode)
          PORT_DATA: begin
            wr_req <= wrt;
            // Reading consumes the buffer, fetch the next byte
            rd_req <= !wrt;
          end
          PORT_CTRL: begin
            if (!wrt) begin
              ctrl_first <= 1'b0;
              clr_v <= (r15 == 8'd0);
              clr_h <= (r15 == 8'd1);
            end else if (!ctrl_first) begin
              ctrl_first <= 1'b1;
            end else begin
              ctrl_first <= 1'b0;
              if (dbo[7]) begin
                case (dbo[5:0])
                  6'd0:  r0 <= ctrl_lat;
                  6'd1:  r1 <= ctrl_lat;
                  6'd7:  r7 <= ctrl_lat;
                  6'd14: r14 <= ctrl_lat;
                  6'd15: r15 <= ctrl_lat;
                  6'd16: begin
                    r16 <= ctrl_lat;
                    pal_first <= 1'b0;
                  end
                  6'd19: r19 <= ctrl_lat;
                  default: ;
                endcase
              end else begin
                addr_set <= 1'b1;
                // Read address set starts the prefetch
                rd_req <= !dbo[6];
              end
            end
          end
          PORT_PALETTE: begin
            if (wrt) begin
              pal_first <= !pal_first;
              if (pal_first) begin
                pal_we <= 1'b1;
                r16[3:0] <= r16[3:0] + 4'd1;
              end
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Payload captured with each accepted access
  always_ff @(posedge RESET) begin
    if (accept) begin
      dbi <= rd_mux;
      wr_data <= dbo;
      set_addr <= {r14[2:0], dbo[5:0], ctrl_lat};
      pal_idx <= r16[3:0];
      pal_rgb <= '{r: pal_lat[6:4], g: dbo[2:0], b: pal_lat[2:0]};
      if (mode == PORT_CTRL && wrt && !ctrl_first) ctrl_lat <= dbo;
      if (mode == PORT_PALETTE && wrt && !pal_first) pal_lat <= dbo;
    end
  end

  // ack is a single-clock pulse even while req is still held
  a_ack_pulse: assert property (@(posedge RESET) disable iff (CLK21M) ack |=> !ack);

endmodule

/* verilog/vdp_pkg.sv */
// VDP shared types
// Data bytes, VRAM addresses, palette entries and the small enums
// used between the CPU port, VRAM slot and colour blocks

`include "vdp_cfg.svh"

package vdp_pkg;

  typedef logic [7:0] vdp_data_t;
  typedef logic [`VDP_VRAM_AW-1:0] vram_addr_t;
  typedef logic [3:0] color_code_t;
  typedef logic [7:0] video_t;

  // 3 bits per component, 9 bits per entry
  typedef struct packed {
    logic [2:0] r;
    logic [2:0] g;
    logic [2:0] b;
  } pal_entry_t;

  typedef enum logic [1:0] {
    PORT_DATA     = 2'b00,
    PORT_CTRL     = 2'b01,
    PORT_PALETTE  = 2'b10,
    PORT_INDIRECT = 2'b11
  } port_mode_e;

  // Gray-coded dot sequence
  typedef enum logic [1:0] {
    DOT_S0 = 2'b00,
    DOT_S1 = 2'b01,
    DOT_S2 = 2'b11,
    DOT_S3 = 2'b10
  } dot_state_e;

endpackage

/* include/vdp_cfg.svh */
// VDP core configuration
// Widths, palette size, raster landmarks and the VRAM slot phase
// shared by the package and the RTL blocks

`ifndef VDP_CFG_SVH
`define VDP_CFG_SVH

// Memory and palette
`define VDP_VRAM_AW      17
`define VDP_PAL_ENTRIES  16

// --------------------
// Raster landmarks, cx and cy are 10 bits
// --------------------
`define VDP_VBLANK_CY    10'd464
`define VDP_TOP_CY       10'd40
`define VDP_HINT_CX      10'd656
`define VDP_H_VISIBLE    10'd640
`define VDP_V_VISIBLE    10'd480

// Dot state that owns the CPU VRAM access
`define VDP_SLOT_PHASE   2'b01

`endif
